// File: src/axi_rd_pkg.sv
/*
  Shared AXI4 read-path field types, encodings and queue payloads.
  Imported by the splitter, the merger and the bridge top level.
*/

`default_nettype none

package axi_rd_pkg;

  // ==============================
  // AXI4 field types
  // ==============================
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  id_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [2:0]  prot_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  // ==============================
  // Queue payloads
  // ==============================
  // One tag per issued Lite read
  typedef struct packed {
    id_t  id;
    logic last;
  } rd_tag_t;

  // One entry per returned Lite data beat
  typedef struct packed {
    data_t data;
    resp_t resp;
  } rd_beat_t;

  localparam int DEF_TAG_DEPTH  = 4;
  localparam int DEF_BEAT_DEPTH = 4;

endpackage

`default_nettype wire

// File: src/beat_fifo.sv
/*
  Synchronous valid/ready FIFO with a type parameter for its payload.
  Used for both the tag queue and the Lite data beat queue.
*/

`timescale 1ns/1ns
`default_nettype none

module beat_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  // Full and empty come straight from the count register
  assign in_ready  = (count != CW'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(push) - CW'(pop);
    end
  end

endmodule

`default_nettype wire

// File: src/ar_burst_splitter.sv
/*
  Splits one AXI4 read burst into single-beat AXI4-Lite reads.
  Each Lite AR goes out together with a tag push that carries the
  burst ID and a last flag for the R-side merger.
*/

`timescale 1ns/1ns
`default_nettype none

module ar_burst_splitter (
  input  logic                clk,
  input  logic                rstn,
  // AXI4 AR side
  input  logic                s_ar_valid,
  output logic                s_ar_ready,
  input  axi_rd_pkg::id_t     s_ar_id,
  input  axi_rd_pkg::addr_t   s_ar_addr,
  input  axi_rd_pkg::len_t    s_ar_len,
  input  axi_rd_pkg::size_t   s_ar_size,
  input  axi_rd_pkg::burst_t  s_ar_burst,
  input  axi_rd_pkg::prot_t   s_ar_prot,
  // Lite AR side
  output logic                m_ar_valid,
  input  logic                m_ar_ready,
  output axi_rd_pkg::addr_t   m_ar_addr,
  output axi_rd_pkg::prot_t   m_ar_prot,
  // Tag push
  output logic                tag_valid,
  input  logic                tag_ready,
  output axi_rd_pkg::rd_tag_t tag_data
);

  import axi_rd_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_ISSUE
  } state_t;

  state_t state;

  id_t    burst_id;
  len_t   burst_len;
  size_t  burst_size;
  burst_t burst_type;
  prot_t  burst_prot;
  addr_t  base_addr;
  addr_t  cur_addr;
  len_t   beat_cnt;

  logic   ar_accept;
  logic   beat_fire;
  logic   beat_last;
  addr_t  next_addr;

  assign s_ar_ready = (state == ST_IDLE);
  assign ar_accept  = s_ar_valid & s_ar_ready;

  // A beat leaves only when the Lite slave and the tag queue both take it
  assign m_ar_valid = (state == ST_ISSUE) & tag_ready;
  assign tag_valid  = (state == ST_ISSUE) & m_ar_ready;
  assign beat_fire  = (state == ST_ISSUE) & m_ar_ready & tag_ready;
  assign beat_last  = (beat_cnt == burst_len);

  assign m_ar_addr = cur_addr;
  assign m_ar_prot = burst_prot;
  assign tag_data  = '{id: burst_id, last: beat_last};

  // Beat k+1 of an INCR burst sits at the aligned base plus (k+1) beat sizes
  assign next_addr = base_addr + ((addr_t'(beat_cnt) + addr_t'(1)) << burst_size);

  // ==============================
  // FSM
  // ==============================
  always_ff @(posedge clk)
  begin
    if (!rstn)
      state <= ST_IDLE;
    else if (ar_accept)
      state <= ST_ISSUE;
    else if (beat_fire && beat_last)
      state <= ST_IDLE;
  end

  // Burst registers and running address
  always_ff @(posedge clk)
  begin
    if (ar_accept)
    begin
      burst_id   <= s_ar_id;
      burst_len  <= s_ar_len;
      burst_size <= s_ar_size;
      burst_type <= s_ar_burst;
      burst_prot <= s_ar_prot;
      base_addr  <= s_ar_addr & (~addr_t'(0) << s_ar_size);
      cur_addr   <= s_ar_addr;
      beat_cnt   <= '0;
    end
    else if (beat_fire)
    begin
      beat_cnt <= beat_cnt + 1'b1;
      if (burst_type != BURST_FIXED)
        cur_addr <= next_addr;
    end
  end

endmodule

`default_nettype wire

// File: src/r_beat_merger.sv
/*
  Joins queued read tags with queued Lite data beats into AXI4 R beats.
  The output is a single registered slot that refills while draining.
*/

`timescale 1ns/1ns
`default_nettype none

module r_beat_merger (
  input  logic                 clk,
  input  logic                 rstn,
  // Tag FIFO side
  input  logic                 tag_valid,
  output logic                 tag_ready,
  input  axi_rd_pkg::rd_tag_t  tag_data,
  // Beat FIFO side
  input  logic                 beat_valid,
  output logic                 beat_ready,
  input  axi_rd_pkg::rd_beat_t beat_data,
  // AXI4 R side
  output logic                 s_r_valid,
  input  logic                 s_r_ready,
  output axi_rd_pkg::id_t      s_r_id,
  output axi_rd_pkg::data_t    s_r_data,
  output axi_rd_pkg::resp_t    s_r_resp,
  output logic                 s_r_last
);

  import axi_rd_pkg::*;

  logic  slot_free;
  logic  take;

  id_t   out_id;
  data_t out_data;
  resp_t out_resp;
  logic  out_last;

  // Slot can load when empty or when its beat leaves this cycle
  assign slot_free = ~s_r_valid | s_r_ready;
  assign take      = tag_valid & beat_valid & slot_free;

  // Both queues pop together on one decision
  assign tag_ready  = take;
  assign beat_ready = take;

  assign s_r_id   = out_id;
  assign s_r_data = out_data;
  assign s_r_resp = out_resp;
  assign s_r_last = out_last;

  always_ff @(posedge clk)
  begin
    if (!rstn)
      s_r_valid <= 1'b0;
    else if (take)
      s_r_valid <= 1'b1;
    else if (s_r_ready)
      s_r_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      out_id   <= tag_data.id;
      out_last <= tag_data.last;
      out_data <= beat_data.data;
      out_resp <= beat_data.resp;
    end
  end

endmodule

`default_nettype wire

// File: src/axi4_read_bridge.sv
/*
  Read-only AXI4 to AXI4-Lite bridge.
  Splitter feeds Lite ARs and a tag queue; Lite R data is queued and
  merged with the tags back into an AXI4 R burst.
*/

`timescale 1ns/1ns
`default_nettype none

module axi4_read_bridge #(
  parameter int TAG_DEPTH  = axi_rd_pkg::DEF_TAG_DEPTH,
  parameter int BEAT_DEPTH = axi_rd_pkg::DEF_BEAT_DEPTH
) (
  input  logic               clk,
  input  logic               rstn,
  // AXI4 slave AR
  input  logic               s_ar_valid,
  output logic               s_ar_ready,
  input  axi_rd_pkg::id_t    s_ar_id,
  input  axi_rd_pkg::addr_t  s_ar_addr,
  input  axi_rd_pkg::len_t   s_ar_len,
  input  axi_rd_pkg::size_t  s_ar_size,
  input  axi_rd_pkg::burst_t s_ar_burst,
  input  axi_rd_pkg::prot_t  s_ar_prot,
  // AXI4 slave R
  output logic               s_r_valid,
  input  logic               s_r_ready,
  output axi_rd_pkg::id_t    s_r_id,
  output axi_rd_pkg::data_t  s_r_data,
  output axi_rd_pkg::resp_t  s_r_resp,
  output logic               s_r_last,
  // Lite master AR
  output logic               m_ar_valid,
  input  logic               m_ar_ready,
  output axi_rd_pkg::addr_t  m_ar_addr,
  output axi_rd_pkg::prot_t  m_ar_prot,
  // Lite master R
  input  logic               m_r_valid,
  output logic               m_r_ready,
  input  axi_rd_pkg::data_t  m_r_data,
  input  axi_rd_pkg::resp_t  m_r_resp
);

  import axi_rd_pkg::*;

  logic     tag_in_valid;
  logic     tag_in_ready;
  rd_tag_t  tag_in_data;
  logic     tag_out_valid;
  logic     tag_out_ready;
  rd_tag_t  tag_out_data;

  rd_beat_t beat_in_data;
  logic     beat_out_valid;
  logic     beat_out_ready;
  rd_beat_t beat_out_data;

  assign beat_in_data = '{data: m_r_data, resp: m_r_resp};

  ar_burst_splitter i_splitter (
    .clk(clk), .rstn(rstn),
    .s_ar_valid(s_ar_valid), .s_ar_ready(s_ar_ready), .s_ar_id(s_ar_id),
    .s_ar_addr(s_ar_addr), .s_ar_len(s_ar_len), .s_ar_size(s_ar_size),
    .s_ar_burst(s_ar_burst), .s_ar_prot(s_ar_prot),
    .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
    .m_ar_addr(m_ar_addr), .m_ar_prot(m_ar_prot),
    .tag_valid(tag_in_valid), .tag_ready(tag_in_ready), .tag_data(tag_in_data)
  );

  beat_fifo #(.payload_t(rd_tag_t), .DEPTH(TAG_DEPTH)) i_tag_fifo (
    .clk(clk), .rstn(rstn),
    .in_valid(tag_in_valid), .in_ready(tag_in_ready), .in_data(tag_in_data),
    .out_valid(tag_out_valid), .out_ready(tag_out_ready), .out_data(tag_out_data)
  );

  // Lite R lands directly in the beat queue
  beat_fifo #(.payload_t(rd_beat_t), .DEPTH(BEAT_DEPTH)) i_beat_fifo (
    .clk(clk), .rstn(rstn),
    .in_valid(m_r_valid), .in_ready(m_r_ready), .in_data(beat_in_data),
    .out_valid(beat_out_valid), .out_ready(beat_out_ready), .out_data(beat_out_data)
  );

  r_beat_merger i_merger (
    .clk(clk), .rstn(rstn),
    .tag_valid(tag_out_valid), .tag_ready(tag_out_ready), .tag_data(tag_out_data),
    .beat_valid(beat_out_valid), .beat_ready(beat_out_ready), .beat_data(beat_out_data),
    .s_r_valid(s_r_valid), .s_r_ready(s_r_ready), .s_r_id(s_r_id),
    .s_r_data(s_r_data), .s_r_resp(s_r_resp), .s_r_last(s_r_last)
  );

endmodule

`default_nettype wire

// File: sim/axi4_read_bridge_assert.sv
/*
  Handshake checker bound into the read bridge.
  Covers valid and payload hold on the Lite AR and AXI4 R channels.
*/

`timescale 1ns/1ns
`default_nettype none

module axi4_read_bridge_assert (
  input logic              clk,
  input logic              rstn,
  input logic              s_ar_valid,
  input logic              s_ar_ready,
  input logic              m_ar_valid,
  input logic              m_ar_ready,
  input axi_rd_pkg::addr_t m_ar_addr,
  input axi_rd_pkg::prot_t m_ar_prot,
  input logic              s_r_valid,
  input logic              s_r_ready,
  input axi_rd_pkg::id_t   s_r_id,
  input axi_rd_pkg::data_t s_r_data,
  input axi_rd_pkg::resp_t s_r_resp,
  input logic              s_r_last
);

  int fail_count = 0;

  a_m_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar_addr) && $stable(m_ar_prot))
  else
  begin
    $error("m_ar_valid or its payload changed before m_ar_ready");
    fail_count++;
  end

  a_s_r_hold: assert property (@(posedge clk) disable iff (!rstn)
    s_r_valid && !s_r_ready |=> s_r_valid && $stable({s_r_id, s_r_data, s_r_resp, s_r_last}))
  else
  begin
    $error("s_r_valid or its payload changed before s_r_ready");
    fail_count++;
  end

  // No new burst is taken while beats are still being issued
  a_ar_busy: assert property (@(posedge clk) disable iff (!rstn)
    m_ar_valid |-> !s_ar_ready)
  else
  begin
    $error("s_ar_ready high while a burst is issuing");
    fail_count++;
  end

endmodule

bind axi4_read_bridge axi4_read_bridge_assert i_assert (.*);

`default_nettype wire

// File: sim/tb_axi4_read_bridge.sv
/*
  Directed testbench for the AXI4 to AXI4-Lite read bridge.
  A Lite slave model answers reads; each test task drives AR bursts
  and checks the Lite addresses and the returned R beats.
*/

`timescale 1ns/1ns
`default_nettype none

module tb_axi4_read_bridge;

  import axi_rd_pkg::*;

  localparam int MAX_CYCLES = 4000;

  logic clk = 1'b0;
  logic rstn;
  logic s_ar_valid, s_ar_ready, s_r_valid, s_r_ready, s_r_last;
  logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
  id_t s_ar_id, s_r_id;
  addr_t s_ar_addr, m_ar_addr;
  len_t s_ar_len;
  size_t s_ar_size;
  burst_t s_ar_burst;
  prot_t s_ar_prot, m_ar_prot;
  data_t s_r_data, m_r_data;
  resp_t s_r_resp, m_r_resp;

  int cycle_cnt = 0;
  logic stall_en = 1'b0;
  logic [31:0] rand_state = 32'hc073;
  logic [31:0] rnd;
  addr_t resp_addr;
  addr_t ar_q[$];
  addr_t seen_addr_q[$];
  prot_t seen_prot_q[$];
  addr_t exp_addr_q[$];
  prot_t exp_prot_q[$];
  id_t exp_id_q[$];
  data_t exp_data_q[$];
  resp_t exp_resp_q[$];
  logic exp_last_q[$];

  axi4_read_bridge i_dut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "run stopped at first error");
  endtask

  // ==============================
  // Lite slave model and stalls
  // ==============================
  always @(posedge clk)
  begin
    if (!rstn)
    begin
      m_r_valid <= 1'b0;
      ar_q.delete();
    end
    else
    begin
      if (m_ar_valid && m_ar_ready)
      begin
        ar_q.push_back(m_ar_addr);
        seen_addr_q.push_back(m_ar_addr);
        seen_prot_q.push_back(m_ar_prot);
      end
      if (!m_r_valid || m_r_ready)
      begin
        if (ar_q.size() > 0)
        begin
          resp_addr = ar_q.pop_front();
          m_r_valid <= 1'b1;
          m_r_data  <= resp_addr ^ 32'h5a5a0000;
          m_r_resp  <= resp_addr[31] ? RESP_SLVERR : RESP_OKAY;
        end
        else
          m_r_valid <= 1'b0;
      end
    end
  end

  // Roughly one cycle in four is stalled on each ready
  always @(posedge clk)
  begin
    rnd = next_rand();
    m_ar_ready <= stall_en ? (rnd[27] | rnd[22]) : 1'b1;
    s_r_ready  <= stall_en ? (rnd[30] | rnd[19]) : 1'b1;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
      stop_on_error("Timeout: the run did not finish within the cycle limit");
    if (i_dut.i_assert.fail_count != 0)
      stop_on_error("A handshake assertion in the bridge failed");
  end

  // ==============================
  // Compare tasks
  // ==============================
  task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic compare_prot(input string name, input prot_t got, input prot_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic compare_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic compare_id(input string name, input id_t got, input id_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic compare_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic compare_last(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_on_error($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  // ==============================
  // Burst helpers
  // ==============================
  // Expected Lite addresses and R beats by the split and slave rules
  task automatic expect_burst(input id_t id, input addr_t addr, input len_t len,
                              input size_t size, input burst_t burst);
    addr_t a;
    addr_t base;
    base = addr & ~((addr_t'(1) << size) - 1);
    for (int k = 0; k <= int'(len); k++)
    begin
      a = (k == 0 || burst == BURST_FIXED) ? addr : base + (addr_t'(k) << size);
      exp_addr_q.push_back(a);
      exp_prot_q.push_back(prot_t'(id));
      exp_id_q.push_back(id);
      exp_data_q.push_back(a ^ 32'h5a5a0000);
      exp_resp_q.push_back(a[31] ? RESP_SLVERR : RESP_OKAY);
      exp_last_q.push_back(k == int'(len));
    end
  endtask

  // Called right after a rising edge; returns on the edge of the handshake
  // Each burst carries the low bits of its ID as prot
  task automatic send_ar(input id_t id, input addr_t addr, input len_t len,
                         input size_t size, input burst_t burst);
    s_ar_valid <= 1'b1;
    s_ar_id    <= id;
    s_ar_addr  <= addr;
    s_ar_len   <= len;
    s_ar_size  <= size;
    s_ar_burst <= burst;
    s_ar_prot  <= prot_t'(id);
    @(posedge clk);
    while (!s_ar_ready)
      @(posedge clk);
    s_ar_valid <= 1'b0;
  endtask

  task automatic collect_beats(input int n);
    int got;
    got = 0;
    while (got < n)
    begin
      @(posedge clk);
      if (s_r_valid && s_r_ready)
      begin
        if (exp_id_q.size() == 0)
          stop_on_error("An R beat arrived that no burst expected");
        compare_id("s_r_id", s_r_id, exp_id_q.pop_front());
        compare_data("s_r_data", s_r_data, exp_data_q.pop_front());
        compare_resp("s_r_resp", s_r_resp, exp_resp_q.pop_front());
        compare_last("s_r_last", s_r_last, exp_last_q.pop_front());
        got++;
      end
    end
  endtask

  task automatic check_lite_addrs_and_quiet();
    if (seen_addr_q.size() != exp_addr_q.size())
      stop_on_error($sformatf("The Lite slave saw %0d reads but %0d were expected",
                              seen_addr_q.size(), exp_addr_q.size()));
    foreach (exp_addr_q[i])
    begin
      compare_addr("m_ar_addr", seen_addr_q[i], exp_addr_q[i]);
      compare_prot("m_ar_prot", seen_prot_q[i], exp_prot_q[i]);
    end
    seen_addr_q.delete();
    seen_prot_q.delete();
    exp_addr_q.delete();
    exp_prot_q.delete();
    repeat (10)
    begin
      @(posedge clk);
      if (s_r_valid || m_ar_valid)
        stop_on_error("The bridge kept issuing after all beats were returned");
    end
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic run_one_burst(input id_t id, input addr_t addr, input len_t len,
                               input size_t size, input burst_t burst);
    expect_burst(id, addr, len, size, burst);
    fork
      send_ar(id, addr, len, size, burst);
      collect_beats(int'(len) + 1);
    join
    check_lite_addrs_and_quiet();
  endtask

  task automatic test_single_beat();
    run_one_burst(4'h5, 32'h0000_0100, 8'd0, 3'd2, BURST_INCR);
  endtask

  task automatic test_incr_unaligned();
    run_one_burst(4'h2, 32'h0000_1006, 8'd7, 3'd2, BURST_INCR);
  endtask

  task automatic test_fixed_repeat();
    run_one_burst(4'ha, 32'h0000_0a10, 8'd3, 3'd2, BURST_FIXED);
  endtask

  task automatic test_slverr();
    run_one_burst(4'h7, 32'h8000_0100, 8'd3, 3'd2, BURST_INCR);
  endtask

  task automatic test_back_to_back();
    stall_en <= 1'b1;
    expect_burst(4'h3, 32'h0000_2000, 8'd3, 3'd2, BURST_INCR);
    expect_burst(4'h9, 32'h0000_3004, 8'd1, 3'd2, BURST_FIXED);
    expect_burst(4'hc, 32'h0000_4002, 8'd5, 3'd1, BURST_INCR);
    fork
      begin
        send_ar(4'h3, 32'h0000_2000, 8'd3, 3'd2, BURST_INCR);
        send_ar(4'h9, 32'h0000_3004, 8'd1, 3'd2, BURST_FIXED);
        send_ar(4'hc, 32'h0000_4002, 8'd5, 3'd1, BURST_INCR);
      end
      collect_beats(12);
    join
    stall_en <= 1'b0;
    check_lite_addrs_and_quiet();
  endtask

  initial
  begin
    rstn       = 1'b0;
    s_ar_valid = 1'b0;
    s_ar_id    = '0;
    s_ar_addr  = '0;
    s_ar_len   = '0;
    s_ar_size  = '0;
    s_ar_burst = BURST_INCR;
    s_ar_prot  = '0;
    s_r_ready  = 1'b1;
    m_ar_ready = 1'b1;
    m_r_valid  = 1'b0;
    m_r_data   = '0;
    m_r_resp   = RESP_OKAY;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    test_single_beat();
    test_incr_unaligned();
    test_fixed_repeat();
    test_slverr();
    test_back_to_back();
    if (i_dut.i_assert.fail_count != 0)
      stop_on_error("A handshake assertion in the bridge failed");
    else
    begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: build.f
src/axi_rd_pkg.sv
src/beat_fifo.sv
src/ar_burst_splitter.sv
src/r_beat_merger.sv
src/axi4_read_bridge.sv
sim/axi4_read_bridge_assert.sv
sim/tb_axi4_read_bridge.sv
